// ==== Makefile ====
# Verilator build and run for the mono video path

VERILATOR := verilator
TOP       := mono_video_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_LOG   := sim.log
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --assert --Mdir $(OBJ_DIR)
FAIL_MSG  := TEST RESULT: FAIL
PASS_MSG  := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# The log decides the result, so a stopped run still gets searched
sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@if grep -q "$(FAIL_MSG)" $(SIM_LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(SIM_LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== bench/mono_video_properties.sv ====
// Control and sync rules only, pixel values are left to the testbench; bound into every mono_video_top
`timescale 1ns/1ps

module mono_video_properties (
	input logic                 CLK_50M,
	input logic                 reset_wire,
	input logic                 out_valid,
	input logic                 core_ready,
	input mono_pkg::video_out_t video_out
);

	//////////////////////////////////////////////////////////////////////
	// Reset hold
	//////////////////////////////////////////////////////////////////////

	// Nothing leaves the pipe before the hold ends
	valid_needs_ready_a: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		!(out_valid && !core_ready))
		else $error("out_valid high while core_ready is low");

	// Raw reset always pulls core_ready down
	ready_low_after_reset_a: assert property (@(posedge CLK_50M)
		reset_wire |=> !core_ready)
		else $error("core_ready high in the cycle after reset_wire");

	//////////////////////////////////////////////////////////////////////
	// Sync
	//////////////////////////////////////////////////////////////////////

	// Gaps carry no display enable
	de_needs_valid_a: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		video_out.sync.de |-> out_valid)
		else $error("video_out de high without out_valid");

endmodule

bind mono_video_top mono_video_properties props_i (
	.CLK_50M    (CLK_50M),
	.reset_wire (reset_wire),
	.out_valid  (out_valid),
	.core_ready (core_ready),
	.video_out  (video_out)
);

// ==== bench/mono_video_tb.sv ====
// Random pixels from a 16-bit LFSR, seed 3; stops at the first error, latency counted from drive edge
`timescale 1ns/1ps
`include "mono_config.svh"

module mono_video_tb;

	// Driven at edge k, sampled at k+1, out after k+2
	localparam int unsigned PIPE_LAT = 2;
	localparam int CHAN_W = `MONO_CHAN_W;
	localparam int OUT_W = `MONO_OUT_W;
	localparam int unsigned LUMA_MAX = (1 << CHAN_W) - 1;
	localparam int HOLD_LIMIT = 64;
	localparam int DRAIN_LIMIT = 16;

	// Expected result and the cycle it is due
	typedef struct packed {
		mono_pkg::video_out_t out;
		logic [31:0]          due;
	} expect_t;

	logic                 CLK_50M;
	logic                 reset_wire;
	logic                 pix_valid;
	mono_pkg::video_in_t  video_in;
	mono_pkg::video_out_t video_out;
	logic                 out_valid;
	logic                 core_ready;

	int unsigned cycle = 0;
	logic [15:0] lfsr = 16'd3;
	expect_t     exp_q[$];

	mono_video_top dut_i (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.pix_valid  (pix_valid),
		.video_in   (video_in),
		.video_out  (video_out),
		.out_valid  (out_valid),
		.core_ready (core_ready)
	);

	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	// Rising edges so far
	always @(posedge CLK_50M) begin
		cycle <= cycle + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Failure and checks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, want));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus source
	//////////////////////////////////////////////////////////////////////

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit
	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic random_pixel(input mono_pkg::tint_mode_t mode, input logic mda,
			output mono_pkg::video_in_t px);
		logic [31:0] bits;
		random_bits(CHAN_W, bits);
		px.pix.r = bits[CHAN_W-1:0];
		random_bits(CHAN_W, bits);
		px.pix.g = bits[CHAN_W-1:0];
		random_bits(CHAN_W, bits);
		px.pix.b = bits[CHAN_W-1:0];
		// hs, vs, de
		random_bits(3, bits);
		px.sync = bits[2:0];
		px.mode = mode;
		px.mda  = mda;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Two zero bits below the 6-bit value
	function automatic logic [OUT_W-1:0] widen(input int unsigned v);
		return OUT_W'(v * 4);
	endfunction

	function automatic mono_pkg::video_out_t expected_output(input mono_pkg::video_in_t vin);
		int unsigned wr;
		int unsigned wg;
		int unsigned wb;
		int unsigned luma;
		int unsigned r;
		int unsigned g;
		int unsigned b;
		mono_pkg::video_out_t res;
		// Original channels, replaced below by a tint
		r = vin.pix.r;
		g = vin.pix.g;
		b = vin.pix.b;
		// Each term rounded to nearest 256th
		wr = (r * `MONO_COEF_R + `MONO_ROUND) / 256;
		wg = (g * `MONO_COEF_G + `MONO_ROUND) / 256;
		wb = (b * `MONO_COEF_B + `MONO_ROUND) / 256;
		luma = wr + wg + wb;
		if (luma > LUMA_MAX) begin
			luma = LUMA_MAX;
		end
		// MDA and colour keep the pixel
		if (!vin.mda) begin
			case (vin.mode)
				mono_pkg::tint_green: begin
					r = 0;
					g = luma;
					b = 0;
				end
				mono_pkg::tint_amber: begin
					r = luma;
					g = luma / 2;
					b = 0;
				end
				mono_pkg::tint_bw: begin
					r = luma;
					g = luma;
					b = luma;
				end
				default: begin
				end
			endcase
		end
		res.pix.r = widen(r);
		res.pix.g = widen(g);
		res.pix.b = widen(b);
		res.sync  = vin.sync;
		return res;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Driving
	//////////////////////////////////////////////////////////////////////

	// Counter still holds the previous edge here
	task automatic drive_inputs(input mono_pkg::video_in_t px, input logic valid,
			output logic [31:0] due);
		@(posedge CLK_50M);
		video_in  <= px;
		pix_valid <= valid;
		due = cycle + 1 + PIPE_LAT;
	endtask

	task automatic push_expected(input mono_pkg::video_in_t px, input logic [31:0] due);
		expect_t entry;
		entry.out = expected_output(px);
		entry.due = due;
		exp_q.push_back(entry);
	endtask

	task automatic send_pixel(input mono_pkg::video_in_t px, input logic valid);
		logic [31:0] due;
		drive_inputs(px, valid, due);
		if (valid) begin
			push_expected(px, due);
		end
	endtask

	// Mixed mode draws mode, mda and gaps per pixel
	task automatic send_random(input int n, input logic mixed, input mono_pkg::tint_mode_t mode,
			input logic mda);
		logic [31:0]         bits;
		mono_pkg::video_in_t px;
		logic                valid;
		for (int i = 0; i < n; i++) begin
			valid = 1'b1;
			random_pixel(mode, mda, px);
			if (mixed) begin
				random_bits(6, bits);
				// About one cycle in four is a gap
				valid   = |bits[1:0];
				px.mode = mono_pkg::tint_mode_t'(bits[3:2]);
				px.mda  = &bits[5:4];
			end
			send_pixel(px, valid);
		end
	endtask

	task automatic wait_for_drain();
		int waited = 0;
		while (exp_q.size() != 0) begin
			@(posedge CLK_50M);
			waited++;
			if (waited > DRAIN_LIMIT) begin
				abort_run("The pipeline did not deliver every accepted pixel");
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Comparing process, sampled mid-cycle
	//////////////////////////////////////////////////////////////////////

	initial begin : compare_outputs
		expect_t want;
		forever begin
			@(negedge CLK_50M);
			if (out_valid && !core_ready) begin
				abort_run("out_valid was high while core_ready was low");
			end
			if (video_out.sync.de && !out_valid) begin
				abort_run("Display enable was high in a gap");
			end
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("out_valid was high with no pixel outstanding");
				end
				want = exp_q.pop_front();
				// Catches early, late and gap outputs
				check_value("out_valid cycle", cycle, want.due);
				check_value("video_out.pix.r", 32'(video_out.pix.r), 32'(want.out.pix.r));
				check_value("video_out.pix.g", 32'(video_out.pix.g), 32'(want.out.pix.g));
				check_value("video_out.pix.b", 32'(video_out.pix.b), 32'(want.out.pix.b));
				check_value("video_out.sync", 32'(video_out.sync), 32'(want.out.sync));
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : run_test
		mono_pkg::video_in_t px;
		logic [31:0]         due;
		logic                ready_seen;
		int                  hold_cycles;
		reset_wire  = 1'b1;
		pix_valid   = 1'b0;
		video_in    = '0;
		ready_seen  = 1'b0;
		hold_cycles = 0;
		repeat (3) begin
			@(posedge CLK_50M);
			@(negedge CLK_50M);
			check_value("core_ready", 32'(core_ready), 32'd0);
			check_value("video_out", 32'(video_out), 32'd0);
		end
		@(posedge CLK_50M);
		reset_wire <= 1'b0;
		// Pixels offered all through the hold
		while (!ready_seen) begin
			random_pixel(mono_pkg::tint_color, 1'b0, px);
			drive_inputs(px, 1'b1, due);
			@(negedge CLK_50M);
			if (core_ready) begin
				ready_seen = 1'b1;
			end else begin
				// Blank and no syncs while held
				check_value("video_out", 32'(video_out), 32'd0);
				hold_cycles++;
				if (hold_cycles > HOLD_LIMIT) begin
					abort_run("core_ready never rose after reset_wire was released");
				end
			end
		end
		check_value("core_ready delay", hold_cycles, 32'(`MONO_RESET_HOLD));
		// Pixel driven on the edge that raised core_ready gets in
		push_expected(px, due);
		send_random(200, 1'b0, mono_pkg::tint_color, 1'b0);
		send_random(200, 1'b0, mono_pkg::tint_green, 1'b0);
		send_random(200, 1'b0, mono_pkg::tint_amber, 1'b0);
		send_random(200, 1'b0, mono_pkg::tint_bw, 1'b0);
		// Bypass under every mode
		for (int m = 0; m < 4; m++) begin
			send_random(50, 1'b0, mono_pkg::tint_mode_t'(2'(m)), 1'b1);
		end
		send_random(300, 1'b1, mono_pkg::tint_color, 1'b0);
		drive_inputs(px, 1'b0, due);
		wait_for_drain();
		// Room for a stray output
		repeat (4) @(posedge CLK_50M);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== rtl/luma_weight_stage.sv ====
// First video stage, one cycle; weights need CHAN_W+COEF_W bits of product without overflow
`timescale 1ns/1ps
`include "mono_config.svh"

module luma_weight_stage (
	input  logic                 CLK_50M,
	input  logic                 reset_wire,
	input  logic                 pipe_reset,
	input  logic                 pix_valid,
	input  mono_pkg::video_in_t  video_in,
	output mono_pkg::weighted_t  weighted
);

	// Product plus rounding offset
	localparam int PROD_W = `MONO_CHAN_W + `MONO_COEF_W;

	// Control state
	logic                    valid_q;
	mono_pkg::sync_bits_t    sync_q;

	// Payload
	mono_pkg::rgb6_t         pix_q;
	logic [`MONO_CHAN_W-1:0] w_r_q;
	logic [`MONO_CHAN_W-1:0] w_g_q;
	logic [`MONO_CHAN_W-1:0] w_b_q;
	mono_pkg::tint_mode_t    mode_q;
	logic                    mda_q;

	//////////////////////////////////////////////////////////////////////
	// Weighted channel term
	//////////////////////////////////////////////////////////////////////

	// (chan * coef + 128) >> 8
	// Replaces the hand-filled weight tables
	function automatic logic [`MONO_CHAN_W-1:0] weigh(
		input logic [`MONO_CHAN_W-1:0] chan,
		input logic [`MONO_COEF_W-1:0] coef
	);
		logic [PROD_W-1:0] prod;
		prod = PROD_W'(chan) * PROD_W'(coef) + PROD_W'(`MONO_ROUND);
		// Drop the 8 fraction bits
		return prod[`MONO_COEF_W +: `MONO_CHAN_W];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Valid and sync
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			valid_q <= 1'b0;
			sync_q  <= '0;
		end else if (pipe_reset) begin
			// Pixels offered during the hold are dropped here
			valid_q <= 1'b0;
			sync_q  <= '0;
		end else begin
			valid_q   <= pix_valid;
			sync_q.hs <= video_in.sync.hs;
			sync_q.vs <= video_in.sync.vs;
			// No display enable in a gap
			sync_q.de <= video_in.sync.de & pix_valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Payload, loaded every cycle
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M) begin
		pix_q  <= video_in.pix;
		w_r_q  <= weigh(video_in.pix.r, `MONO_COEF_R);
		w_g_q  <= weigh(video_in.pix.g, `MONO_COEF_G);
		w_b_q  <= weigh(video_in.pix.b, `MONO_COEF_B);
		// Mode travels with its pixel
		mode_q <= video_in.mode;
		mda_q  <= video_in.mda;
	end

	// Bundle for the tint stage
	assign weighted = '{
		valid: valid_q,
		pix:   pix_q,
		w_r:   w_r_q,
		w_g:   w_g_q,
		w_b:   w_b_q,
		sync:  sync_q,
		mode:  mode_q,
		mda:   mda_q
	};

endmodule

// ==== rtl/mono_config.svh ====
// Widths and constants for the mono video path; luma weights assume 6-bit input channels
`ifndef MONO_CONFIG_SVH
`define MONO_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Channel widths
//////////////////////////////////////////////////////////////////////

// Input colour channel, as delivered by the CGA/MDA scan logic
`define MONO_CHAN_W 6
// Output colour channel towards the VGA DAC
`define MONO_OUT_W 8

//////////////////////////////////////////////////////////////////////
// Luma weights
//////////////////////////////////////////////////////////////////////

// Weights in 256ths, close to Rec.709 luma
`define MONO_COEF_W 8
`define MONO_COEF_R 8'd54
`define MONO_COEF_G 8'd183
`define MONO_COEF_B 8'd18
// Half an LSB, added before dropping the fraction
`define MONO_ROUND 128

//////////////////////////////////////////////////////////////////////
// Reset hold
//////////////////////////////////////////////////////////////////////

`define MONO_HOLD_W 16
// Cycles the pipeline stays in reset once reset_wire is gone
`define MONO_RESET_HOLD 16'd16

`endif

// ==== rtl/mono_pkg.sv ====
// Types shared by the mono video stages; field order sets the packed layout the bench relies on
`include "mono_config.svh"

package mono_pkg;

	// Tint selection, per pixel
	// Encoding follows the CGA RGB menu entry
	typedef enum logic [1:0] {
		tint_color = 2'd0,
		tint_green = 2'd1,
		tint_amber = 2'd2,
		tint_bw    = 2'd3
	} tint_mode_t;

	// Sync and display enable
	typedef struct packed {
		logic hs;
		logic vs;
		logic de;
	} sync_bits_t;

	// Raw 6-bit pixel
	typedef struct packed {
		logic [`MONO_CHAN_W-1:0] r;
		logic [`MONO_CHAN_W-1:0] g;
		logic [`MONO_CHAN_W-1:0] b;
	} rgb6_t;

	// Widened pixel for the DAC
	typedef struct packed {
		logic [`MONO_OUT_W-1:0] r;
		logic [`MONO_OUT_W-1:0] g;
		logic [`MONO_OUT_W-1:0] b;
	} rgb8_t;

	//////////////////////////////////////////////////////////////////////
	// Bundles between stages
	//////////////////////////////////////////////////////////////////////

	// Top-level input, 24 bits
	typedef struct packed {
		rgb6_t      pix;
		sync_bits_t sync;
		tint_mode_t mode;
		// MDA bypass, pixel goes out untouched
		logic       mda;
	} video_in_t;

	// Stage 1 result, 43 bits
	typedef struct packed {
		logic                    valid;
		rgb6_t                   pix;
		logic [`MONO_CHAN_W-1:0] w_r;
		logic [`MONO_CHAN_W-1:0] w_g;
		logic [`MONO_CHAN_W-1:0] w_b;
		sync_bits_t              sync;
		tint_mode_t              mode;
		logic                    mda;
	} weighted_t;

	// Top-level output, 27 bits
	typedef struct packed {
		rgb8_t      pix;
		sync_bits_t sync;
	} video_out_t;

endpackage

// ==== rtl/mono_video_top.sv ====
// Monochrome monitor emulation, two cycles input to output; no back-pressure, pixels drop until ready
`timescale 1ns/1ps

module mono_video_top (
	input  logic                 CLK_50M,
	input  logic                 reset_wire,
	input  logic                 pix_valid,
	input  mono_pkg::video_in_t  video_in,
	output mono_pkg::video_out_t video_out,
	output logic                 out_valid,
	output logic                 core_ready
);

	// Synchronous release for both stages
	logic                pipe_reset;
	// Stage 1 to stage 2
	mono_pkg::weighted_t weighted;

	//////////////////////////////////////////////////////////////////////
	// Reset hold
	//////////////////////////////////////////////////////////////////////

	reset_stretcher reset_stretcher_i (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.pipe_reset (pipe_reset),
		.core_ready (core_ready)
	);

	//////////////////////////////////////////////////////////////////////
	// Video pipeline
	//////////////////////////////////////////////////////////////////////

	// Acceptance gated here through pipe_reset
	luma_weight_stage luma_weight_stage_i (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.pipe_reset (pipe_reset),
		.pix_valid  (pix_valid),
		.video_in   (video_in),
		.weighted   (weighted)
	);

	// Luma sum, tint and widening
	tint_stage tint_stage_i (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.pipe_reset (pipe_reset),
		.weighted   (weighted),
		.video_out  (video_out),
		.out_valid  (out_valid)
	);

endmodule

// ==== rtl/reset_stretcher.sv ====
// Holds the pipeline in reset for MONO_RESET_HOLD cycles after reset_wire falls; hold must be nonzero
`timescale 1ns/1ps
`include "mono_config.svh"

module reset_stretcher (
	input  logic CLK_50M,
	input  logic reset_wire,
	output logic pipe_reset,
	output logic core_ready
);

	// Hold counter, saturates at the hold count
	logic [`MONO_HOLD_W-1:0] hold_cnt;
	logic                    hold_done;
	logic                    pipe_reset_q;
	logic                    core_ready_q;

	assign hold_done = (hold_cnt == `MONO_RESET_HOLD);

	//////////////////////////////////////////////////////////////////////
	// Count out the hold after an asynchronous reset
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			hold_cnt     <= '0;
			pipe_reset_q <= 1'b1;
			core_ready_q <= 1'b0;
		end else begin
			// Stop once reached, no wrap back into reset
			if (!hold_done) begin
				hold_cnt <= hold_cnt + 1'b1;
			end
			// Release is synchronous to CLK_50M
			pipe_reset_q <= !hold_done;
			core_ready_q <= hold_done;
		end
	end

	// Both flags change on the same edge
	assign pipe_reset = pipe_reset_q;
	assign core_ready = core_ready_q;

endmodule

// ==== rtl/tint_stage.sv ====
// Second video stage, one cycle; output colour is cleared only by reset, not in valid gaps
`timescale 1ns/1ps
`include "mono_config.svh"

module tint_stage (
	input  logic                 CLK_50M,
	input  logic                 reset_wire,
	input  logic                 pipe_reset,
	input  mono_pkg::weighted_t  weighted,
	output mono_pkg::video_out_t video_out,
	output logic                 out_valid
);

	// Sum of three 6-bit terms needs two more bits
	localparam int SUM_W = `MONO_CHAN_W + 2;
	// Zero bits appended when widening
	localparam int PAD_W = `MONO_OUT_W - `MONO_CHAN_W;

	logic [SUM_W-1:0]        luma_sum;
	logic [`MONO_CHAN_W-1:0] luma;
	logic [`MONO_CHAN_W-1:0] luma_half;
	mono_pkg::rgb6_t         tinted;
	mono_pkg::rgb8_t         tinted_wide;
	mono_pkg::video_out_t    out_q;
	logic                    valid_q;

	//////////////////////////////////////////////////////////////////////
	// Luma
	//////////////////////////////////////////////////////////////////////

	assign luma_sum = SUM_W'(weighted.w_r) + SUM_W'(weighted.w_g) + SUM_W'(weighted.w_b);

	// Clamp to full scale
	assign luma = (|luma_sum[SUM_W-1:`MONO_CHAN_W]) ? '1 : luma_sum[`MONO_CHAN_W-1:0];

	// Amber green channel, rounded down
	assign luma_half = luma >> 1;

	//////////////////////////////////////////////////////////////////////
	// Tint select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Colour and MDA both keep the original pixel
		tinted = weighted.pix;
		if (!weighted.mda) begin
			case (weighted.mode)
				mono_pkg::tint_green: begin
					tinted = '{r: '0, g: luma, b: '0};
				end
				mono_pkg::tint_amber: begin
					tinted = '{r: luma, g: luma_half, b: '0};
				end
				mono_pkg::tint_bw: begin
					tinted = '{r: luma, g: luma, b: luma};
				end
				default: begin
					tinted = weighted.pix;
				end
			endcase
		end
	end

	// 6 to 8 bits, low bits zero
	assign tinted_wide.r = {tinted.r, {PAD_W{1'b0}}};
	assign tinted_wide.g = {tinted.g, {PAD_W{1'b0}}};
	assign tinted_wide.b = {tinted.b, {PAD_W{1'b0}}};

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			out_q   <= '0;
			valid_q <= 1'b0;
		end else if (pipe_reset) begin
			// Blank screen and no syncs during the hold
			out_q   <= '0;
			valid_q <= 1'b0;
		end else begin
			out_q.pix  <= tinted_wide;
			out_q.sync <= weighted.sync;
			valid_q    <= weighted.valid;
		end
	end

	assign video_out = out_q;
	assign out_valid = valid_q;

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/mono_pkg.sv
rtl/reset_stretcher.sv
rtl/luma_weight_stage.sv
rtl/tint_stage.sv
rtl/mono_video_top.sv
bench/mono_video_properties.sv
bench/mono_video_tb.sv
